// File: fb_defs.svh
// ================================================
// display timing, framebuffer geometry and the
// bus widths shared by the display RTL
// ================================================

`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// visible area
`define FB_H_RES 640
`define FB_V_RES 480

// horizontal porches and sync, 800 clocks per line
`define FB_H_FP 16
`define FB_H_SYNC 96
`define FB_H_BP 48

// vertical porches and sync, 525 lines per frame
`define FB_V_FP 10
`define FB_V_SYNC 2
`define FB_V_BP 33

`define FB_CORDW 16       // signed screen coordinate width

// framebuffer, 1 bit per pixel
`define FB_WIDTH 160
`define FB_HEIGHT 120
`define FB_PIXELS 19200
`define FB_ADDRW 15

`define FB_COLRW 12       // 4 bits per channel
`define FB_CFG_ADDRW 2

`endif

// File: fb_pkg.sv
// ================================================
// shared structs and enums for the framebuffer
// display: position, syncs, writes, colours, FSM
// ================================================

`default_nettype none

`include "fb_defs.svh"

package fb_pkg;

    // current beam position, signed as in the timing generator
    typedef struct packed {
        logic signed [`FB_CORDW-1:0] sx;
        logic signed [`FB_CORDW-1:0] sy;
    } screen_pos_t;

    typedef struct packed {
        logic hsync;    // active low
        logic vsync;    // active low
        logic de;       // visible area
        logic frame;    // start of vertical blanking
        logic line;     // start of every line
    } sync_t;

    // one framebuffer write
    typedef struct packed {
        logic                 we;
        logic [`FB_ADDRW-1:0] addr;
        logic                 colr;
    } fb_wr_t;

    typedef struct packed {
        logic [`FB_COLRW-1:0] fg;   // set pixels
        logic [`FB_COLRW-1:0] bg;   // clear pixels
    } colour_cfg_t;

    typedef enum logic {
        CMD_CLEAR = 1'b0,
        CMD_BOX   = 1'b1
    } draw_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        TOP,
        RIGHT,
        LEFT,
        BOTTOM
    } draw_state_e;

    typedef enum logic [`FB_CFG_ADDRW-1:0] {
        REG_FG  = 2'd0,
        REG_BG  = 2'd1,
        REG_CMD = 2'd2
    } cfg_reg_e;

endpackage

`default_nettype wire

// File: display_timings.sv
// ================================================
// 640x480 timing generator: beam position, syncs,
// data enable, frame and line pulses
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module display_timings (
    input  wire logic         clk_pix,
    input  wire logic         rst_n,
    output fb_pkg::screen_pos_t pos,
    output fb_pkg::sync_t       sync
);

    localparam int HS_STA = `FB_H_RES + `FB_H_FP;   // 656
    localparam int HS_END = HS_STA + `FB_H_SYNC;    // 752, first clock after sync
    localparam int H_LAST = HS_END + `FB_H_BP - 1;  // 799
    localparam int VS_STA = `FB_V_RES + `FB_V_FP;   // 490
    localparam int VS_END = VS_STA + `FB_V_SYNC;
    localparam int V_LAST = VS_END + `FB_V_BP - 1;  // 524

    logic signed [`FB_CORDW-1:0] nxt_sx;
    logic signed [`FB_CORDW-1:0] nxt_sy;

    // next position, so the sync flags can be registered alongside it
    always_comb begin
        if (pos.sx == H_LAST) begin
            nxt_sx = '0;
            nxt_sy = (pos.sy == V_LAST) ? '0 : pos.sy + 1'b1;
        end else begin
            nxt_sx = pos.sx + 1'b1;
            nxt_sy = pos.sy;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pos  <= '0;
            sync <= '0;   // syncs go high on the first step
        end else begin
            pos.sx     <= nxt_sx;
            pos.sy     <= nxt_sy;
            sync.hsync <= ~(nxt_sx >= HS_STA && nxt_sx < HS_END);
            sync.vsync <= ~(nxt_sy >= VS_STA && nxt_sy < VS_END);
            sync.de    <= (nxt_sx >= 0 && nxt_sx < `FB_H_RES &&
                           nxt_sy >= 0 && nxt_sy < `FB_V_RES);
            sync.frame <= (nxt_sx == 0 && nxt_sy == `FB_V_RES);  // blanking starts
            sync.line  <= (nxt_sx == 0);
        end
    end

endmodule

`default_nettype wire

// File: fb_bram.sv
// ================================================
// framebuffer block RAM, one write port and one
// registered read port
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module fb_bram (
    input  wire logic                 clk_pix,
    input  wire fb_pkg::fb_wr_t       wr,
    input  wire logic [`FB_ADDRW-1:0] rd_addr,
    output logic                      rd_data
);

    logic mem [`FB_PIXELS];

    // screen starts blank
    initial begin
        for (int i = 0; i < `FB_PIXELS; i++) begin
            mem[i] = 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.colr;
        end
    end

    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_addr];   // one cycle latency
    end

endmodule

`default_nettype wire

// File: fb_cfg_regs.sv
// ================================================
// colour registers and the pending draw command
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module fb_cfg_regs (
    input  wire logic                     clk_pix,
    input  wire logic                     rst_n,
    input  wire logic                     cfg_we,
    input  wire logic [`FB_CFG_ADDRW-1:0] cfg_addr,
    input  wire logic [`FB_COLRW-1:0]     cfg_wdata,
    input  wire logic                     cmd_ack,
    output fb_pkg::colour_cfg_t           colours,
    output logic                          cmd_pending,
    output fb_pkg::draw_cmd_e             cmd_op
);

    import fb_pkg::*;

    cfg_reg_e wr_reg;

    assign wr_reg = cfg_reg_e'(cfg_addr);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            colours     <= '0;
            cmd_pending <= 1'b0;
            cmd_op      <= CMD_CLEAR;
        end else begin
            if (cmd_ack) begin
                cmd_pending <= 1'b0;
            end
            // a command write in the ack cycle overrides the clear above
            if (cfg_we) begin
                case (wr_reg)
                    REG_FG: colours.fg <= cfg_wdata;
                    REG_BG: colours.bg <= cfg_wdata;
                    REG_CMD: begin
                        cmd_pending <= 1'b1;
                        cmd_op      <= draw_cmd_e'(cfg_wdata[0]);
                    end
                    default: ;   // unused address
                endcase
            end
        end
    end

    // drawing engine must only take a command that is actually pending
    ack_needs_pending: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        cmd_ack |-> cmd_pending
    ) else $error("cmd_ack while no command pending");

endmodule

`default_nettype wire

// File: box_drawer.sv
// ================================================
// drawing engine: clears the framebuffer or traces
// a box round its edge during vertical blanking
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module box_drawer (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire logic              frame,
    input  wire logic              cmd_pending,
    input  wire fb_pkg::draw_cmd_e cmd_op,
    output logic                   cmd_ack,
    output logic                   busy,
    output fb_pkg::fb_wr_t         wr
);

    import fb_pkg::*;

    localparam int CNTW = $clog2(`FB_WIDTH);

    // horizontal edges run 159 cycles, vertical edges 120
    localparam logic [CNTW-1:0]      H_LAST    = CNTW'(`FB_WIDTH - 2);
    localparam logic [CNTW-1:0]      V_LAST    = CNTW'(`FB_HEIGHT - 1);
    localparam logic [`FB_ADDRW-1:0] ROW_STEP  = `FB_WIDTH;
    localparam logic [`FB_ADDRW-1:0] LAST_ADDR = `FB_PIXELS - 1;

    draw_state_e     state;
    logic [CNTW-1:0] edge_cnt;

    // take the command on the frame edge itself
    assign cmd_ack = (state == IDLE) && frame && cmd_pending;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            edge_cnt <= '0;
            busy     <= 1'b0;
            wr       <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_ack) begin
                        busy     <= 1'b1;
                        wr.we    <= 1'b1;
                        wr.addr  <= '0;
                        wr.colr  <= (cmd_op == CMD_BOX);
                        edge_cnt <= '0;
                        state    <= (cmd_op == CMD_BOX) ? TOP : CLEAR;
                    end
                end
                CLEAR: begin
                    if (wr.addr == LAST_ADDR) begin
                        wr.we <= 1'b0;
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else begin
                        wr.addr <= wr.addr + 1'b1;
                    end
                end
                TOP: begin
                    wr.addr <= wr.addr + 1'b1;   // last step lands on the top right corner
                    if (edge_cnt == H_LAST) begin
                        edge_cnt <= '0;
                        state    <= RIGHT;
                    end else begin
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                end
                RIGHT: begin
                    if (edge_cnt == V_LAST) begin
                        wr.addr  <= '0;   // back to top left for the left edge
                        edge_cnt <= '0;
                        state    <= LEFT;
                    end else begin
                        wr.addr  <= wr.addr + ROW_STEP;
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                end
                LEFT: begin
                    if (edge_cnt == V_LAST) begin
                        wr.addr  <= wr.addr + 1'b1;   // bottom row, second pixel
                        edge_cnt <= '0;
                        state    <= BOTTOM;
                    end else begin
                        wr.addr  <= wr.addr + ROW_STEP;
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                end
                BOTTOM: begin
                    if (edge_cnt == H_LAST) begin
                        wr.we <= 1'b0;
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else begin
                        wr.addr  <= wr.addr + 1'b1;
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    wr_addr_in_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        wr.we |-> wr.addr < `FB_PIXELS
    ) else $error("framebuffer write address %0d out of range", wr.addr);

    idle_not_busy: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        (state == IDLE) |-> !busy
    ) else $error("busy set while drawing engine idle");

endmodule

`default_nettype wire

// File: fb_scanout.sv
// ================================================
// framebuffer scanout: read addressing, RAM delay
// alignment and colour mapping to the VGA pins
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module fb_scanout (
    input  wire logic                  clk_pix,
    input  wire logic                  rst_n,
    input  wire fb_pkg::screen_pos_t   pos,
    input  wire fb_pkg::sync_t         sync,
    input  wire fb_pkg::colour_cfg_t   colours,
    input  wire logic                  rd_data,
    output logic [`FB_ADDRW-1:0]       rd_addr,
    output logic                       vga_hsync,
    output logic                       vga_vsync,
    output logic [3:0]                 vga_r,
    output logic [3:0]                 vga_g,
    output logic [3:0]                 vga_b
);

    logic                 paint;
    logic                 paint_p1;
    logic                 hsync_p1;
    logic                 vsync_p1;
    logic [`FB_COLRW-1:0] pix_colr;

    // framebuffer sits in the top left corner
    assign paint = sync.de && pos.sx < `FB_WIDTH && pos.sy < `FB_HEIGHT;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (sync.frame) begin
            rd_addr <= '0;   // rewind for the next frame
        end else if (paint) begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    // match the one cycle RAM read
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            paint_p1 <= 1'b0;
            hsync_p1 <= 1'b0;
            vsync_p1 <= 1'b0;
        end else begin
            paint_p1 <= paint;
            hsync_p1 <= sync.hsync;
            vsync_p1 <= sync.vsync;
        end
    end

    always_comb begin
        if (!paint_p1) begin
            pix_colr = '0;   // black outside the framebuffer
        end else if (rd_data) begin
            pix_colr = colours.fg;
        end else begin
            pix_colr = colours.bg;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= pix_colr[11:8];
            vga_g     <= pix_colr[7:4];
            vga_b     <= pix_colr[3:0];
        end
    end

    // address must have been rewound by the frame pulse before painting
    rd_addr_in_range: assert property (
        @(posedge clk_pix) disable iff (!rst_n)
        paint |-> rd_addr < `FB_PIXELS
    ) else $error("scanout read address %0d out of range", rd_addr);

endmodule

`default_nettype wire

// File: fb_display_top.sv
// ================================================
// display top: timing, config registers, drawing
// engine, framebuffer RAM and scanout
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module fb_display_top (
    input  wire logic                     clk_pix,
    input  wire logic                     rst_n,
    input  wire logic                     cfg_we,
    input  wire logic [`FB_CFG_ADDRW-1:0] cfg_addr,
    input  wire logic [`FB_COLRW-1:0]     cfg_wdata,
    output logic                          draw_busy,
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic [3:0]                    vga_r,
    output logic [3:0]                    vga_g,
    output logic [3:0]                    vga_b
);

    import fb_pkg::*;

    screen_pos_t          pos;
    sync_t                sync;
    colour_cfg_t          colours;
    logic                 cmd_pending;
    draw_cmd_e            cmd_op;
    logic                 cmd_ack;
    fb_wr_t               fb_wr;
    logic [`FB_ADDRW-1:0] fb_rd_addr;
    logic                 fb_rd_data;

    display_timings u_display_timings (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .pos     (pos),
        .sync    (sync)
    );

    fb_cfg_regs u_fb_cfg_regs (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cmd_ack     (cmd_ack),
        .colours     (colours),
        .cmd_pending (cmd_pending),
        .cmd_op      (cmd_op)
    );

    box_drawer u_box_drawer (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .frame       (sync.frame),   // commands start at vertical blanking
        .cmd_pending (cmd_pending),
        .cmd_op      (cmd_op),
        .cmd_ack     (cmd_ack),
        .busy        (draw_busy),
        .wr          (fb_wr)
    );

    fb_bram u_fb_bram (
        .clk_pix (clk_pix),
        .wr      (fb_wr),
        .rd_addr (fb_rd_addr),
        .rd_data (fb_rd_data)
    );

    fb_scanout u_fb_scanout (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .pos       (pos),
        .sync      (sync),
        .colours   (colours),
        .rd_data   (fb_rd_data),
        .rd_addr   (fb_rd_addr),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

// File: tb_fb_display.sv
// ================================================
// testbench for the framebuffer display: register
// writes, screen reference model, sync and colour checks
// ================================================

`default_nettype none
`timescale 1ns/1ps

`include "fb_defs.svh"

module tb_fb_display;

    import fb_pkg::*;

    localparam int H_TOTAL      = `FB_H_RES + `FB_H_FP + `FB_H_SYNC + `FB_H_BP;
    localparam int V_TOTAL      = `FB_V_RES + `FB_V_FP + `FB_V_SYNC + `FB_V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int BLANK_CYCLES = (V_TOTAL - `FB_V_RES) * H_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
    localparam int HS_COL       = `FB_H_RES + `FB_H_FP;   // column at hsync fall
    localparam int VS_ROW       = `FB_V_RES + `FB_V_FP;   // row at vsync fall
    localparam int EV_VS_FALL   = 0;
    localparam int EV_BUSY_RISE = 1;
    localparam int EV_BUSY_FALL = 2;

    logic                     clk_pix;
    logic                     rst_n;
    logic                     cfg_we;
    logic [`FB_CFG_ADDRW-1:0] cfg_addr;
    logic [`FB_COLRW-1:0]     cfg_wdata;
    logic                     draw_busy;
    logic                     vga_hsync;
    logic                     vga_vsync;
    logic [3:0]               vga_r;
    logic [3:0]               vga_g;
    logic [3:0]               vga_b;

    // reference model state
    bit                   model_fb [`FB_PIXELS];
    logic [`FB_COLRW-1:0] fg_m = '0;
    logic [`FB_COLRW-1:0] bg_m = '0;
    logic [`FB_COLRW-1:0] exp_colr = '0;
    draw_cmd_e            cmd_q [$];

    // monitor state, updated on the falling edge
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic busy_s = 1'b0;
    logic hs_fall = 1'b0;
    logic hs_rise = 1'b0;
    logic vs_fall = 1'b0;
    logic vs_rise = 1'b0;
    logic busy_rose = 1'b0;
    logic busy_fell = 1'b0;
    int   cyc;
    int   col;
    int   row;
    int   hs_cnt;
    int   hs_low;
    int   hs_period;
    int   h_falls;
    int   vs_cnt;
    int   vs_low;
    int   vs_period;
    int   v_falls;
    int   busy_rise_cyc;
    int   busy_fall_cyc;

    int err_cnt  = 0;
    int err_mark = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    fb_display_top u_fb_display_top (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .draw_busy (draw_busy),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    task automatic apply_cmd(input draw_cmd_e op);
        int i;
        for (i = 0; i < `FB_PIXELS; i++) begin
            if (op == CMD_CLEAR) model_fb[i] = 1'b0;
        end
        if (op == CMD_BOX) begin
            for (i = 0; i < `FB_WIDTH; i++) begin
                model_fb[i] = 1'b1;                                  // top row
                model_fb[(`FB_HEIGHT - 1) * `FB_WIDTH + i] = 1'b1;   // bottom row
            end
            for (i = 0; i < `FB_HEIGHT; i++) begin
                model_fb[i * `FB_WIDTH] = 1'b1;
                model_fb[i * `FB_WIDTH + `FB_WIDTH - 1] = 1'b1;
            end
        end
    endtask

    // screen position recovered from the vga sync edges
    always @(negedge clk_pix) begin
        cyc++;
        hs_fall   = hs_prev && !vga_hsync;
        hs_rise   = !hs_prev && vga_hsync;
        vs_fall   = vs_prev && !vga_vsync;
        vs_rise   = !vs_prev && vga_vsync;
        busy_rose = draw_busy && !busy_s;
        busy_fell = !draw_busy && busy_s;
        hs_prev   = vga_hsync;
        vs_prev   = vga_vsync;
        busy_s    = draw_busy;
        if (hs_fall) begin
            h_falls++;
            hs_period = hs_cnt + 1;
            hs_cnt    = 0;
            hs_low    = 1;
            col       = HS_COL;
        end else begin
            hs_cnt++;
            if (!vga_hsync) hs_low++;
            col = (col == H_TOTAL - 1) ? 0 : col + 1;
        end
        if (vs_fall) begin
            v_falls++;
            vs_period = vs_cnt + 1;
            vs_cnt    = 0;
            vs_low    = 1;
            row       = VS_ROW;
        end else begin
            vs_cnt++;
            if (!vga_vsync) vs_low++;
            if (col == 0) row = (row == V_TOTAL - 1) ? 0 : row + 1;
        end
        if (busy_rose) busy_rise_cyc = cyc;
        if (busy_fell) begin
            busy_fall_cyc = cyc;
            if (cmd_q.size() == 0) begin
                err_cnt++;
                $display("draw_busy fell at %0t with no command outstanding", $time);
            end else begin
                apply_cmd(cmd_q.pop_front());   // takes effect from the next frame
            end
        end
        if (col < `FB_WIDTH && row < `FB_HEIGHT)
            exp_colr = model_fb[row * `FB_WIDTH + col] ? fg_m : bg_m;
        else
            exp_colr = '0;
    end

    hsync_low_time: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (hs_rise && h_falls > 0) |-> hs_low == `FB_H_SYNC)
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_hsync low cycles expected %0d got %0d",
                 $time, `FB_H_SYNC, $sampled(hs_low));
    end

    hsync_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (hs_fall && h_falls > 1) |-> hs_period == H_TOTAL)
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_hsync period expected %0d got %0d",
                 $time, H_TOTAL, $sampled(hs_period));
    end

    vsync_low_time: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (vs_rise && v_falls > 0) |-> vs_low == `FB_V_SYNC * H_TOTAL)
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_vsync low cycles expected %0d got %0d",
                 $time, `FB_V_SYNC * H_TOTAL, $sampled(vs_low));
    end

    vsync_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (vs_fall && v_falls > 1) |-> vs_period == FRAME_CYCLES)
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_vsync period expected %0d got %0d",
                 $time, FRAME_CYCLES, $sampled(vs_period));
    end

    busy_ends_in_blanking: assert property (@(posedge clk_pix) disable iff (!rst_n)
        busy_fell |-> row >= `FB_V_RES)
    else begin
        err_cnt++;
        $display("draw_busy fell outside vertical blanking at %0t, row %0d",
                 $time, $sampled(row));
    end

    red_matches: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vga_r == exp_colr[11:8])
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_r expected %h got %h",
                 $time, $sampled(exp_colr[11:8]), $sampled(vga_r));
    end

    green_matches: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vga_g == exp_colr[7:4])
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_g expected %h got %h",
                 $time, $sampled(exp_colr[7:4]), $sampled(vga_g));
    end

    blue_matches: assert property (@(posedge clk_pix) disable iff (!rst_n)
        vga_b == exp_colr[3:0])
    else begin
        err_cnt++;
        $display("[FAIL] %0t vga_b expected %h got %h",
                 $time, $sampled(exp_colr[3:0]), $sampled(vga_b));
    end

    task automatic abort_run(input string why);
        $display("timeout waiting for %s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // event flags come from the falling edge monitor
    task automatic wait_for(input int which, input string what);
        int n;
        bit hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < WAIT_LIMIT) begin
            @(posedge clk_pix);
            n++;
            case (which)
                EV_VS_FALL:   hit = vs_fall;
                EV_BUSY_RISE: hit = busy_rose;
                default:      hit = busy_fell;
            endcase
        end
        if (!hit) abort_run(what);
    endtask

    task automatic wait_frames(input int n);
        repeat (n) wait_for(EV_VS_FALL, "vga_vsync falling edge");
    endtask

    task automatic write_reg(input cfg_reg_e addr, input logic [`FB_COLRW-1:0] data);
        @(posedge clk_pix);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk_pix);
        #1;
        cfg_we = 1'b0;
        @(posedge clk_pix);   // new colour leaves the output register here
        #1;
        if (addr == REG_FG) fg_m = data;
        if (addr == REG_BG) bg_m = data;
    endtask

    task automatic issue_cmd(input draw_cmd_e op);
        cmd_q.push_back(op);
        write_reg(REG_CMD, `FB_COLRW'(op));
    endtask

    function automatic logic [`FB_COLRW-1:0] pick_colour(input logic [`FB_COLRW-1:0] avoid);
        logic [`FB_COLRW-1:0] c;
        do begin
            c = `FB_COLRW'($urandom_range(1, 4095));
        end while (c == avoid);
        return c;
    endfunction

    task automatic check_draw_time();
        assert (busy_fall_cyc - busy_rise_cyc < BLANK_CYCLES)
        else begin
            err_cnt++;
            $display("draw_busy stayed high %0d cycles, longer than vertical blanking",
                     busy_fall_cyc - busy_rise_cyc);
        end
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s ok", name);
        end else begin
            fail_cnt++;
            $display("test %s failed with %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    initial begin
        int clear_rise;
        logic [`FB_COLRW-1:0] new_bg;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        rst_n     = 1'b0;
        void'($urandom(28824));
        repeat (16) @(posedge clk_pix);
        #1;
        rst_n = 1'b1;

        wait_frames(3);   // lock, then two full frame periods
        end_test("sync timing");

        write_reg(REG_BG, pick_colour('0));
        wait_frames(1);
        end_test("reset black and background");

        write_reg(REG_FG, pick_colour(bg_m));
        issue_cmd(CMD_BOX);
        wait_for(EV_BUSY_RISE, "draw_busy rise on box");
        wait_for(EV_BUSY_FALL, "draw_busy fall on box");
        check_draw_time();
        wait_frames(2);   // box blanking, then the first box frame
        end_test("box");

        new_bg = pick_colour(bg_m);
        write_reg(REG_BG, new_bg);
        write_reg(REG_FG, pick_colour(new_bg));
        wait_frames(1);
        end_test("live colours");

        issue_cmd(CMD_CLEAR);
        wait_for(EV_BUSY_RISE, "draw_busy rise on clear");
        wait_for(EV_BUSY_FALL, "draw_busy fall on clear");
        check_draw_time();
        wait_frames(1);
        end_test("clear");

        issue_cmd(CMD_CLEAR);
        wait_for(EV_BUSY_RISE, "draw_busy rise on clear");
        clear_rise = busy_rise_cyc;
        issue_cmd(CMD_BOX);   // lands while the clear is running
        wait_for(EV_BUSY_FALL, "draw_busy fall on clear");
        wait_for(EV_BUSY_RISE, "draw_busy rise on pending box");
        assert (busy_rise_cyc - clear_rise == FRAME_CYCLES)
        else begin
            err_cnt++;
            $display("pending box started %0d cycles after the clear, not one frame",
                     busy_rise_cyc - clear_rise);
        end
        wait_for(EV_BUSY_FALL, "draw_busy fall on pending box");
        wait_frames(2);
        end_test("pending while busy");

        $display("tests passed: %0d  failed: %0d  check errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
fb_pkg.sv
display_timings.sv
fb_bram.sv
fb_cfg_regs.sv
box_drawer.sv
fb_scanout.sv
fb_display_top.sv
tb_fb_display.sv

// File: Bender.yml
package:
  name: fb_display

sources:
  - include_dirs:
      - .
    files:
      - fb_pkg.sv
      - display_timings.sv
      - fb_bram.sv
      - fb_cfg_regs.sv
      - box_drawer.sv
      - fb_scanout.sv
      - fb_display_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fb_display.sv
